//--- source/bus_fabric_pkg.sv
package bus_fabric_pkg;

   //**************************************************************************
   // bus geometry
   //**************************************************************************
   localparam int BUS_ADR_W = 16;            // byte address
   localparam int BUS_DAT_W = 16;            // data word
   localparam int BUS_SEL_W = 2;             // byte lanes
   localparam int RAM_ADR_W = 15;            // word address into main RAM

   // main RAM ends where the I/O area starts
   localparam logic [BUS_ADR_W-1:0] RAM_TOP = 16'o160000;

   localparam int N_IO_SLAVES = 8;

   //**************************************************************************
   // I/O page windows
   //**************************************************************************
   // value doubles as index into the slave arrays
   typedef enum logic [2:0] {
      IO_UART1,                              // console
      IO_UART2,                              // second serial port
      IO_LPT,                                // printer
      IO_RK,                                 // RK disk regs
      IO_DW,                                 // DW hard disk regs
      IO_RX,                                 // RX floppy regs
      IO_MY,                                 // MY floppy regs
      IO_KGD                                 // graphics
   } io_slave_e;

   // window base, in io_slave_e order
   localparam logic [BUS_ADR_W-1:0] IO_BASE [N_IO_SLAVES] = '{
      16'o177560, 16'o176500, 16'o177514, 16'o177400,
      16'o174000, 16'o177170, 16'o172140, 16'o176640
   };

   // low address bits not compared inside a window
   localparam int unsigned IO_SPAN [N_IO_SLAVES] = '{3, 3, 2, 4, 5, 2, 2, 3};

   //**************************************************************************
   // bus bundles
   //**************************************************************************
   typedef struct packed {
      logic [BUS_ADR_W-1:0] adr;
      logic [BUS_DAT_W-1:0] dat;             // write data
      logic                 cyc;             // cycle, DMA request for disk masters
      logic                 we;
      logic [BUS_SEL_W-1:0] sel;
      logic                 stb;
   } bus_req_t;

   typedef struct packed {
      logic [BUS_DAT_W-1:0] dat;             // read data
      logic                 ack;
   } bus_rsp_t;

   typedef logic [N_IO_SLAVES-1:0] io_stb_t;            // one strobe per slave
   typedef bus_rsp_t [N_IO_SLAVES-1:0] io_rsp_t;        // answers of all slaves

   // who drives the shared bus
   typedef enum logic [1:0] {
      OWNER_CPU,
      OWNER_RK,
      OWNER_MY
   } bus_owner_e;

endpackage

//--- source/bus_master_switch.sv
`timescale 1ns/100ps

module bus_master_switch (
   input  logic                     clk_sys,
   input  logic                     rst_i,
   input  bus_fabric_pkg::bus_req_t cpu_req_i,
   input  bus_fabric_pkg::bus_req_t rk_req_i,
   input  bus_fabric_pkg::bus_req_t my_req_i,
   input  bus_fabric_pkg::bus_rsp_t bus_rsp_i,   // combined answer from router
   output bus_fabric_pkg::bus_req_t bus_req_o,   // shared bus
   output bus_fabric_pkg::bus_rsp_t cpu_rsp_o,
   output bus_fabric_pkg::bus_rsp_t rk_rsp_o,
   output bus_fabric_pkg::bus_rsp_t my_rsp_o,
   output logic                     rk_gnt_o,
   output logic                     my_gnt_o
);

   import bus_fabric_pkg::*;

   bus_owner_e owner_q;                      // current bus master
   bus_owner_e owner_d;

   //**************************************************************************
   // owner arbiter
   //**************************************************************************
   // switch only between cycles, RK first, then MY, else back to CPU
   always_comb begin
      owner_d = owner_q;
      if (!bus_req_o.cyc) begin              // no cycle in flight
         if (rk_req_i.cyc)
            owner_d = OWNER_RK;
         else if (my_req_i.cyc)
            owner_d = OWNER_MY;
         else
            owner_d = OWNER_CPU;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (rst_i)
         owner_q <= OWNER_CPU;               // CPU owns the bus out of reset
      else
         owner_q <= owner_d;
   end

   assign rk_gnt_o = (owner_q == OWNER_RK);
   assign my_gnt_o = (owner_q == OWNER_MY);

   //**************************************************************************
   // request mux
   //**************************************************************************
   always_comb begin
      case (owner_q)
         OWNER_RK: begin
            bus_req_o     = rk_req_i;
            bus_req_o.sel = '1;              // DMA moves whole words
         end
         OWNER_MY: begin
            bus_req_o     = my_req_i;
            bus_req_o.sel = '1;
         end
         default: begin
            bus_req_o = cpu_req_i;           // CPU keeps its byte lanes
         end
      endcase
   end

   // read data goes to all, ack only to the owner
   always_comb begin
      cpu_rsp_o     = bus_rsp_i;
      rk_rsp_o      = bus_rsp_i;
      my_rsp_o      = bus_rsp_i;
      cpu_rsp_o.ack = bus_rsp_i.ack & (owner_q == OWNER_CPU);
      rk_rsp_o.ack  = bus_rsp_i.ack & rk_gnt_o;
      my_rsp_o.ack  = bus_rsp_i.ack & my_gnt_o;
   end

endmodule

//--- source/io_page_router.sv
`timescale 1ns/100ps

module io_page_router (
   input  bus_fabric_pkg::bus_req_t bus_req_i,   // shared bus
   input  logic                     sysram_stb_i, // CPU board system RAM flag
   input  bus_fabric_pkg::bus_rsp_t ram_rsp_i,
   input  bus_fabric_pkg::io_rsp_t  io_rsp_i,
   output logic                     ram_stb_o,
   output bus_fabric_pkg::io_stb_t  io_stb_o,
   output bus_fabric_pkg::bus_rsp_t bus_rsp_o
);

   import bus_fabric_pkg::*;

   logic                 bus_act;            // live strobe on the bus
   logic [BUS_DAT_W-1:0] rd_dat;
   logic                 ack_any;

   assign bus_act = bus_req_i.stb & bus_req_i.cyc;

   //**************************************************************************
   // address decode
   //**************************************************************************
   // compare upper bits only, window size set by IO_SPAN
   always_comb begin
      for (int i = 0; i < N_IO_SLAVES; i++) begin
         io_stb_o[i] = bus_act &
                       (((bus_req_i.adr ^ IO_BASE[i]) >> IO_SPAN[i]) == '0);
      end
   end

   // main RAM below 160000
   // sysram flag maps extra CPU board memory into RAM as well
   assign ram_stb_o = (bus_act & (bus_req_i.adr < RAM_TOP)) | sysram_stb_i;

   //**************************************************************************
   // answer combine
   //**************************************************************************
   always_comb begin
      rd_dat  = '0;                          // nothing strobed reads zero
      ack_any = ram_rsp_i.ack;
      for (int i = 0; i < N_IO_SLAVES; i++) begin
         ack_any = ack_any | io_rsp_i[i].ack;
         if (io_stb_o[i])
            rd_dat = rd_dat | io_rsp_i[i].dat;   // windows never overlap
      end
      if (ram_stb_o)
         rd_dat = ram_rsp_i.dat;             // RAM wins
   end

   assign bus_rsp_o.dat = rd_dat;
   assign bus_rsp_o.ack = ack_any;

endmodule

//--- source/bus_ram.sv
`timescale 1ns/100ps

module bus_ram (
   input  logic                     clk_sys,
   input  logic                     rst_i,
   input  bus_fabric_pkg::bus_req_t bus_req_i,
   input  logic                     stb_i,    // RAM select from router
   output bus_fabric_pkg::bus_rsp_t rsp_o
);

   import bus_fabric_pkg::*;

   logic [BUS_DAT_W-1:0] mem [2**RAM_ADR_W]; // main memory, words
   logic [RAM_ADR_W-1:0] word_adr;
   logic [BUS_DAT_W-1:0] rd_q;
   logic                 ack_q;
   logic                 acc_go;             // accept access this cycle

   assign word_adr = bus_req_i.adr[RAM_ADR_W:1];   // drop byte bit
   // one access per strobe, rearm after ack cycle
   assign acc_go   = stb_i & ~ack_q;

   always_ff @(posedge clk_sys) begin
      if (rst_i)
         ack_q <= 1'b0;
      else
         ack_q <= acc_go;                    // single cycle ack
   end

   always_ff @(posedge clk_sys) begin
      if (acc_go) begin
         rd_q <= mem[word_adr];              // registered with ack
         if (bus_req_i.we) begin
            for (int b = 0; b < BUS_SEL_W; b++) begin
               if (bus_req_i.sel[b])
                  mem[word_adr][b*8 +: 8] <= bus_req_i.dat[b*8 +: 8];
            end
         end
      end
   end

   assign rsp_o.dat = rd_q;
   assign rsp_o.ack = ack_q;

endmodule

//--- source/mc1201_bus_fabric.sv
`timescale 1ns/100ps

module mc1201_bus_fabric (
   input  logic                     clk_sys,
   input  logic                     rst_i,
   // CPU board
   input  bus_fabric_pkg::bus_req_t cpu_req_i,
   input  logic                     sysram_stb_i,
   // DMA disk controllers
   input  bus_fabric_pkg::bus_req_t rk_req_i,
   input  bus_fabric_pkg::bus_req_t my_req_i,
   // external I/O page slaves
   input  bus_fabric_pkg::io_rsp_t  io_rsp_i,
   output bus_fabric_pkg::bus_rsp_t cpu_rsp_o,
   output bus_fabric_pkg::bus_rsp_t rk_rsp_o,
   output bus_fabric_pkg::bus_rsp_t my_rsp_o,
   output logic                     rk_gnt_o,
   output logic                     my_gnt_o,
   output bus_fabric_pkg::bus_req_t io_req_o,   // shared bus to slaves
   output bus_fabric_pkg::io_stb_t  io_stb_o
);

   import bus_fabric_pkg::*;

   bus_req_t bus_req;                        // granted master's request
   bus_rsp_t bus_rsp;                        // combined slave answer
   bus_rsp_t ram_rsp;
   logic     ram_stb;

   //**************************************************************************
   // master side
   //**************************************************************************
   bus_master_switch u_switch (
      .clk_sys   (clk_sys),
      .rst_i     (rst_i),
      .cpu_req_i (cpu_req_i),
      .rk_req_i  (rk_req_i),
      .my_req_i  (my_req_i),
      .bus_rsp_i (bus_rsp),
      .bus_req_o (bus_req),
      .cpu_rsp_o (cpu_rsp_o),
      .rk_rsp_o  (rk_rsp_o),
      .my_rsp_o  (my_rsp_o),
      .rk_gnt_o  (rk_gnt_o),
      .my_gnt_o  (my_gnt_o)
   );

   //**************************************************************************
   // slave side
   //**************************************************************************
   io_page_router u_router (
      .bus_req_i    (bus_req),
      .sysram_stb_i (sysram_stb_i),
      .ram_rsp_i    (ram_rsp),
      .io_rsp_i     (io_rsp_i),
      .ram_stb_o    (ram_stb),
      .io_stb_o     (io_stb_o),
      .bus_rsp_o    (bus_rsp)
   );

   bus_ram u_ram (
      .clk_sys   (clk_sys),
      .rst_i     (rst_i),
      .bus_req_i (bus_req),
      .stb_i     (ram_stb),
      .rsp_o     (ram_rsp)
   );

   assign io_req_o = bus_req;                // I/O slaves see the shared bus

endmodule

//--- dv/io_slave_model.sv
`timescale 1ns/100ps

module io_slave_model #(
   parameter logic [7:0] SEED = 8'h5A       // own delay sequence, nonzero
) (
   input  logic                     clk_sys,
   input  logic                     rst_i,
   input  bus_fabric_pkg::bus_req_t req_i,   // shared bus
   input  logic                     stb_i,   // window select from router
   output bus_fabric_pkg::bus_rsp_t rsp_o
);

   import bus_fabric_pkg::*;

   logic [BUS_DAT_W-1:0] reg_q;              // the one device register
   logic [7:0]           lfsr_q;
   logic [1:0]           dly_q;              // ack delay, 0 to 3 cycles
   logic [1:0]           cnt_q;
   logic                 ack_q;

   // 8 bit galois step
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
   endfunction

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         reg_q  <= '0;
         lfsr_q <= SEED;
         dly_q  <= SEED[1:0];
         cnt_q  <= '0;
         ack_q  <= 1'b0;
      end else if (ack_q) begin
         ack_q  <= 1'b0;                     // one cycle ack
         cnt_q  <= '0;
         dly_q  <= lfsr_q[1:0];              // next delay
         lfsr_q <= lfsr_step(lfsr_step(lfsr_q));   // two bits taken
      end else if (stb_i) begin
         if (cnt_q == dly_q) begin
            ack_q <= 1'b1;
            if (req_i.we) begin
               for (int b = 0; b < BUS_SEL_W; b++) begin
                  if (req_i.sel[b])
                     reg_q[b*8 +: 8] <= req_i.dat[b*8 +: 8];
               end
            end
         end else begin
            cnt_q <= cnt_q + 2'd1;           // still busy
         end
      end
   end

   assign rsp_o.dat = reg_q;                 // router masks by strobe
   assign rsp_o.ack = ack_q;

endmodule

//--- dv/tb_mc1201_bus_fabric.sv
`timescale 1ns/100ps

module tb_mc1201_bus_fabric;

   import bus_fabric_pkg::*;

   localparam int N_RAM = 8;                 // random RAM words
   localparam int N_ACC = 3 * N_RAM + 16 + 6 + 15;   // all bus accesses
   localparam time T_LIMIT = (N_ACC * 20 + 8) * 40ns;

   // windows as given by the address map, base and ignored low bits
   localparam logic [15:0] WIN_BASE [8] = '{16'o177560, 16'o176500, 16'o177514,
      16'o177400, 16'o174000, 16'o177170, 16'o172140, 16'o176640};
   localparam int WIN_BITS [8] = '{3, 3, 2, 4, 5, 2, 2, 3};

   logic     clk_sys = 1'b0;
   logic     rst_i;
   bus_req_t cpu_req, rk_req, my_req, io_req;
   bus_rsp_t cpu_rsp, rk_rsp, my_rsp;
   logic     sysram, rk_gnt, my_gnt;
   logic     rk_seen = 1'b0;                 // RK held the bus at some point
   io_rsp_t  io_rsp;
   io_stb_t  io_stb;

   logic [15:0] lfsr_q = 16'd62;
   logic [15:0] ram_model [int];             // keyed by word address
   logic [15:0] io_model [8];
   logic        exp_vld [3];                 // per master: cpu, rk, my
   logic        exp_we [3];
   logic [15:0] exp_dat [3];
   io_stb_t     exp_stb [3];
   logic [15:0] ram_adr [N_RAM];

   always #20 clk_sys = ~clk_sys;

   mc1201_bus_fabric u_dut (
      .clk_sys (clk_sys), .rst_i (rst_i), .cpu_req_i (cpu_req), .sysram_stb_i (sysram),
      .rk_req_i (rk_req), .my_req_i (my_req), .io_rsp_i (io_rsp),
      .cpu_rsp_o (cpu_rsp), .rk_rsp_o (rk_rsp), .my_rsp_o (my_rsp),
      .rk_gnt_o (rk_gnt), .my_gnt_o (my_gnt), .io_req_o (io_req), .io_stb_o (io_stb)
   );

   for (genvar g = 0; g < 8; g++) begin : g_slave
      io_slave_model #(.SEED(8'h31 + 8'(g * 7))) u_slave (
         .clk_sys (clk_sys), .rst_i (rst_i), .req_i (io_req),
         .stb_i (io_stb[g]), .rsp_o (io_rsp[g])
      );
   end

   //***************************************************************************
   // helpers and reference model
   //***************************************************************************
   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   endtask

   // galois lfsr, one step per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r[i]   = lfsr_q[0];
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      end
      return r;
   endfunction

   function automatic int find_window(input logic [15:0] adr, input logic sys);
      if (sys)
         return -1;                          // sysram always goes to RAM
      for (int i = 0; i < 8; i++)
         if ((adr >> WIN_BITS[i]) == (WIN_BASE[i] >> WIN_BITS[i]))
            return i;
      return -1;
   endfunction

   function automatic io_stb_t window_strobe(input logic [15:0] adr, input logic sys);
      io_stb_t s;
      int      w;
      s = '0;
      w = find_window(adr, sys);
      if (w >= 0)
         s[w] = 1'b1;
      return s;
   endfunction

   function automatic logic [15:0] stored_word(input logic [15:0] adr, input logic sys);
      int w;
      w = find_window(adr, sys);
      if (w >= 0)
         return io_model[w];
      return ram_model.exists(int'(adr[15:1])) ? ram_model[int'(adr[15:1])] : 16'h0;
   endfunction

   // byte merge, DMA masters always write both lanes
   task automatic model_write(input int m, input logic [15:0] adr, input logic [15:0] dat,
                              input logic [1:0] sel, input logic sys);
      logic [1:0]  lanes;
      logic [15:0] w;
      int          win;
      lanes = (m != 0) ? 2'b11 : sel;
      win   = find_window(adr, sys);
      w     = stored_word(adr, sys);
      if (lanes[0])
         w[7:0] = dat[7:0];
      if (lanes[1])
         w[15:8] = dat[15:8];
      if (win >= 0)
         io_model[win] = w;
      else
         ram_model[int'(adr[15:1])] = w;
   endtask

   function automatic bus_rsp_t rsp_of(input int m);
      return (m == 0) ? cpu_rsp : ((m == 1) ? rk_rsp : my_rsp);
   endfunction

   // RAM answers exactly one cycle after the strobe
   task automatic latency_check(input int lat);
      assert (lat == 1) else fail_stop($sformatf(
         "[FAIL] cpu_rsp_o.ack latency got %h expected %h", lat, 1));
   endtask

   // one master access, returns cycles from stb to ack
   task automatic bus_access(input int m, input logic [15:0] adr, input logic [15:0] dat,
                             input logic we, input logic [1:0] sel, input logic sys,
                             input logic hold, output int lat);
      bus_req_t q;
      q          = '{adr: adr, dat: dat, cyc: 1'b1, we: we, sel: sel, stb: 1'b1};
      exp_stb[m] = window_strobe(adr, sys);
      exp_dat[m] = stored_word(adr, sys);
      exp_we[m]  = we;
      exp_vld[m] = 1'b1;
      @(posedge clk_sys);
      case (m)
         0: begin
            cpu_req <= q;
            sysram  <= sys;
         end
         1: rk_req <= q;
         default: my_req <= q;
      endcase
      lat = 0;
      do begin
         @(negedge clk_sys);
         lat++;
      end while (!rsp_of(m).ack);
      lat = lat - 1;
      if (we)
         model_write(m, adr, dat, sel, sys);
      q.stb = 1'b0;
      q.cyc = hold;                          // DMA keeps cyc over a burst
      @(posedge clk_sys);
      exp_vld[m] = 1'b0;
      case (m)
         0: begin
            cpu_req <= q;
            sysram  <= 1'b0;
         end
         1: rk_req <= q;
         default: my_req <= q;
      endcase
   endtask

   task automatic dma_burst(input int m, input logic [15:0] base, input logic [15:0] d0);
      int lat;
      for (int k = 0; k < 3; k++)
         bus_access(m, base + 16'(2 * k), d0 + 16'(k), 1'b1, 2'b00, 1'b0, k < 2, lat);
   endtask

   //***************************************************************************
   // compare process
   //***************************************************************************
   always @(negedge clk_sys) begin
      bus_rsp_t r;
      if (!rst_i) begin
         if (rk_gnt)
            rk_seen = 1'b1;
         assert (!my_gnt || (rk_seen && !rk_req.cyc))
            else fail_stop("my_gnt_o rose before RK had the bus and released it");
         for (int m = 0; m < 3; m++) begin
            r = rsp_of(m);
            if (r.ack) begin
               assert (exp_vld[m])
                  else fail_stop($sformatf("ack to master %0d with no access pending", m));
               assert (io_stb == exp_stb[m]) else fail_stop($sformatf(
                  "[FAIL] io_stb_o got %h expected %h", io_stb, exp_stb[m]));
               assert (exp_we[m] || r.dat == exp_dat[m]) else fail_stop($sformatf(
                  "[FAIL] rsp_o.dat of master %0d got %h expected %h", m, r.dat, exp_dat[m]));
               assert ((m == 0 && !rk_gnt && !my_gnt) || (m == 1 && rk_gnt) ||
                       (m == 2 && my_gnt))
                  else fail_stop($sformatf("master %0d acked while not owning the bus", m));
            end
         end
      end
   end

   initial begin
      #(T_LIMIT);
      $display("run timed out, a master never got its ack");
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

   //***************************************************************************
   // stimulus
   //***************************************************************************
   initial begin
      logic [15:0] a;
      int          lat;
      rst_i   = 1'b1;
      cpu_req = '0;
      rk_req  = '0;
      my_req  = '0;
      sysram  = 1'b0;
      for (int i = 0; i < 3; i++)
         exp_vld[i] = 1'b0;
      for (int i = 0; i < 8; i++)
         io_model[i] = '0;
      repeat (8) @(posedge clk_sys);
      rst_i <= 1'b0;
      @(negedge clk_sys);
      assert (!rk_gnt && !my_gnt && !cpu_rsp.ack && !rk_rsp.ack && !my_rsp.ack && io_stb == '0)
         else fail_stop("outputs not idle after reset");

      // cpu RAM, full word first so every byte is known
      for (int i = 0; i < N_RAM; i++) begin
         ram_adr[i] = rand_bits(13) << 1;    // below 040000 so it misses the DMA buffers
         bus_access(0, ram_adr[i], rand_bits(16), 1'b1, 2'b11, 1'b0, 1'b0, lat);
         latency_check(lat);
         bus_access(0, ram_adr[i], rand_bits(16), 1'b1, 2'(rand_bits(2)), 1'b0, 1'b0, lat);
         latency_check(lat);
      end
      for (int i = 0; i < N_RAM; i++) begin
         bus_access(0, ram_adr[i], 16'h0, 1'b0, 2'b11, 1'b0, 1'b0, lat);
         latency_check(lat);
      end

      // each I/O window
      for (int w = 0; w < 8; w++) begin
         a = (WIN_BASE[w] + rand_bits(WIN_BITS[w])) & 16'hFFFE;
         bus_access(0, a, rand_bits(16), 1'b1, 2'(rand_bits(2)), 1'b0, 1'b0, lat);
         bus_access(0, a, 16'h0, 1'b0, 2'b11, 1'b0, 1'b0, lat);
      end

      // system RAM flag above 160000
      for (int i = 0; i < 2; i++) begin
         a = 16'o160000 + (rand_bits(12) & 16'hFFFE);
         bus_access(0, a, rand_bits(16), 1'b1, 2'b11, 1'b1, 1'b0, lat);
         latency_check(lat);
         bus_access(0, a, rand_bits(16), 1'b1, 2'(rand_bits(2)), 1'b1, 1'b0, lat);
         latency_check(lat);
         bus_access(0, a, 16'h0, 1'b0, 2'b11, 1'b1, 1'b0, lat);
         latency_check(lat);
      end

      // both DMA masters at once, cpu stuck behind them
      fork
         dma_burst(1, 16'o040000, 16'hA500);
         dma_burst(2, 16'o050000, 16'h5A00);
         begin
            repeat (3) @(posedge clk_sys);
            bus_access(0, ram_adr[0], 16'h0, 1'b0, 2'b11, 1'b0, 1'b0, lat);
         end
      join
      for (int k = 0; k < 3; k++) begin
         bus_access(0, 16'o040000 + 16'(2 * k), 16'h0, 1'b0, 2'b11, 1'b0, 1'b0, lat);
         bus_access(0, 16'o050000 + 16'(2 * k), 16'h0, 1'b0, 2'b11, 1'b0, 1'b0, lat);
      end

      // DMA reads get the shared read data back
      bus_access(1, 16'o050000, 16'h0, 1'b0, 2'b00, 1'b0, 1'b0, lat);
      bus_access(2, 16'o040000, 16'h0, 1'b0, 2'b00, 1'b0, 1'b0, lat);

      repeat (2) @(posedge clk_sys);
      $display("TEST PASSED");
      $finish;
   end

endmodule

//--- mc1201_bus_fabric.f
source/bus_fabric_pkg.sv
source/bus_master_switch.sv
source/io_page_router.sv
source/bus_ram.sv
source/mc1201_bus_fabric.sv
dv/io_slave_model.sv
dv/tb_mc1201_bus_fabric.sv

//--- Makefile
# Verilator simulation of the MC1201 bus fabric

VERILATOR ?= verilator
SIM_TOP   ?= tb_mc1201_bus_fabric
FILELIST  ?= mc1201_bus_fabric.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails on a failing run"
	@echo "  clean  remove build output"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
